// File: source/fpu_settings.svh
`ifndef FPU_SETTINGS_SVH
`define FPU_SETTINGS_SVH

// field widths
`define LEN_WORD  32
`define LEN_FUNC3 3
`define LEN_FUNC7 7

// func7 codes of the single-cycle class
`define FUNC7_FSGNJ 7'b0010000
`define FUNC7_FCOMP 7'b1010000
`define FUNC7_ITOF  7'b1101000
`define FUNC7_FTOI  7'b1100000
// float reg to int reg, int reg to float reg
`define FUNC7_FMVI  7'b1110000
`define FUNC7_IMVF  7'b1111000

// func3 for sign injection
`define FUNC3_SGNJ  3'd0
`define FUNC3_SGNJN 3'd1
`define FUNC3_SGNJX 3'd2

// func3 for compare
`define FUNC3_FLE   3'd0
`define FUNC3_FLT   3'd1
`define FUNC3_FEQ   3'd2

`endif

// File: source/fpu_pkg.sv
`default_nettype none

`include "fpu_settings.svh"

package fpu_pkg;

    // one order as it arrives from the core
    typedef struct packed {
        logic [`LEN_FUNC7-1:0] func7;
        logic [`LEN_FUNC3-1:0] func3;
        logic [`LEN_WORD-1:0]  rs1;
        logic [`LEN_WORD-1:0]  rs2;
    } fpu_request_t;

    // single precision fields
    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
    } float_t;

    // decoded destination of an order
    typedef enum logic [2:0] {
        sel_sgnj,
        sel_comp,
        sel_itof,
        sel_ftoi,
        sel_move,
        sel_error
    } unit_sel_e;

endpackage

`default_nettype wire

// File: source/fpu_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_settings.svh"

module fpu_dispatch
    import fpu_pkg::*;
(
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  order,
    input  wire fpu_request_t    request,
    output logic                 accepted,
    output logic                 done,
    output logic [`LEN_WORD-1:0] rd,
    output logic                 sgnj_order,
    output logic                 comp_order,
    output logic                 itof_order,
    output logic                 ftoi_order,
    input  wire                  sgnj_done,
    input  wire                  comp_done,
    input  wire                  itof_done,
    input  wire                  ftoi_done,
    input  wire [`LEN_WORD-1:0]  sgnj_rd,
    input  wire [`LEN_WORD-1:0]  comp_rd,
    input  wire [`LEN_WORD-1:0]  itof_rd,
    input  wire [`LEN_WORD-1:0]  ftoi_rd
);

    unit_sel_e            sel;
    logic                 busy;
    logic                 move_done;
    logic                 error_done;
    logic [`LEN_WORD-1:0] rd_buf;
    logic [`LEN_WORD-1:0] next_rd;

    // unknown func7 or func3 falls through to the error path
    always_comb begin
        case (request.func7)
            `FUNC7_FSGNJ: sel = (request.func3 <= `FUNC3_SGNJX) ? sel_sgnj : sel_error;
            `FUNC7_FCOMP: sel = (request.func3 <= `FUNC3_FEQ) ? sel_comp : sel_error;
            `FUNC7_ITOF:  sel = sel_itof;
            `FUNC7_FTOI:  sel = sel_ftoi;
            `FUNC7_FMVI,
            `FUNC7_IMVF:  sel = sel_move;
            default:      sel = sel_error;
        endcase
    end

    assign accepted   = order & ~busy;
    assign sgnj_order = accepted & (sel == sel_sgnj);
    assign comp_order = accepted & (sel == sel_comp);
    assign itof_order = accepted & (sel == sel_itof);
    assign ftoi_order = accepted & (sel == sel_ftoi);
    // moves and errors finish in the accept cycle
    assign move_done  = accepted & (sel == sel_move);
    assign error_done = accepted & (sel == sel_error);

    assign done = sgnj_done | comp_done | itof_done | ftoi_done | move_done | error_done;

    always_comb begin
        if (sgnj_done)
            next_rd = sgnj_rd;
        else if (comp_done)
            next_rd = comp_rd;
        else if (itof_done)
            next_rd = itof_rd;
        else if (ftoi_done)
            next_rd = ftoi_rd;
        else if (move_done)
            next_rd = request.rs1;
        else if (error_done)
            next_rd = '0;
        else
            next_rd = rd_buf;
    end

    assign rd = next_rd;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            rd_buf <= '0;
        end else begin
            busy   <= ~done & (busy | accepted);
            rd_buf <= next_rd;
        end
    end

    a_one_done: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({sgnj_done, comp_done, itof_done, ftoi_done, move_done, error_done}));

    // no new order while a two-stage unit is still working
    a_hold_off: assert property (@(posedge clk) disable iff (!arst_n)
        (itof_order || ftoi_order) |=> !accepted ##1 !accepted);

    a_lat_one: assert property (@(posedge clk) disable iff (!arst_n)
        (sgnj_order || comp_order) |=> (sgnj_done || comp_done));

    a_lat_two: assert property (@(posedge clk) disable iff (!arst_n)
        (itof_order || ftoi_order) |=> ##1 (itof_done || ftoi_done));

endmodule

`default_nettype wire

// File: source/fsgnj.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_settings.svh"

module fsgnj
    import fpu_pkg::*;
(
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  order,
    input  wire [`LEN_FUNC3-1:0] func3,
    input  wire [`LEN_WORD-1:0]  rs1,
    input  wire [`LEN_WORD-1:0]  rs2,
    output logic                 done,
    output logic [`LEN_WORD-1:0] rd
);

    float_t op_a;
    float_t op_b;
    logic   sign;

    assign op_a = rs1;
    assign op_b = rs2;

    always_comb begin
        case (func3)
            `FUNC3_SGNJN: sign = ~op_b.sign;
            `FUNC3_SGNJX: sign = op_a.sign ^ op_b.sign;
            default:      sign = op_b.sign;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            done <= 1'b0;
        else
            done <= order;
    end

    // magnitude of rs1 is kept as is
    always_ff @(posedge clk) begin
        if (order)
            rd <= {sign, op_a.exp, op_a.frac};
    end

endmodule

`default_nettype wire

// File: source/fcomp.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_settings.svh"

module fcomp
    import fpu_pkg::*;
(
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  order,
    input  wire [`LEN_FUNC3-1:0] func3,
    input  wire [`LEN_WORD-1:0]  rs1,
    input  wire [`LEN_WORD-1:0]  rs2,
    output logic                 done,
    output logic [`LEN_WORD-1:0] rd
);

    float_t op_a;
    float_t op_b;
    logic   any_nan;
    logic   both_zero;
    logic   eq;
    logic   lt;
    logic   hit;

    assign op_a = rs1;
    assign op_b = rs2;

    assign any_nan = ((&op_a.exp) && (|op_a.frac)) || ((&op_b.exp) && (|op_b.frac));
    // +0 and -0 compare equal
    assign both_zero = ({op_a.exp, op_a.frac} == '0) && ({op_b.exp, op_b.frac} == '0);
    assign eq = both_zero || (rs1 == rs2);

    // sign first, then magnitude, reversed for negatives
    always_comb begin
        if (op_a.sign != op_b.sign)
            lt = op_a.sign && !both_zero;
        else if (op_a.sign)
            lt = {op_a.exp, op_a.frac} > {op_b.exp, op_b.frac};
        else
            lt = {op_a.exp, op_a.frac} < {op_b.exp, op_b.frac};
    end

    always_comb begin
        case (func3)
            `FUNC3_FEQ: hit = eq;
            `FUNC3_FLT: hit = lt;
            default:    hit = lt | eq;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            done <= 1'b0;
        else
            done <= order;
    end

    always_ff @(posedge clk) begin
        if (order)
            rd <= {{(`LEN_WORD-1){1'b0}}, hit & ~any_nan};
    end

    // dispatcher only routes the three compare codes here
    a_known_func3: assert property (@(posedge clk) disable iff (!arst_n)
        order |-> func3 inside {`FUNC3_FLE, `FUNC3_FLT, `FUNC3_FEQ});

endmodule

`default_nettype wire

// File: source/itof.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_settings.svh"

module itof
    import fpu_pkg::*;
(
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  order,
    input  wire [`LEN_WORD-1:0]  rs1,
    output logic                 done,
    output logic [`LEN_WORD-1:0] rd
);

    logic [`LEN_WORD-1:0] abs_val;
    logic [4:0]           lz;
    logic                 s1_valid;
    logic                 s1_sign;
    logic                 s1_zero;
    logic [`LEN_WORD-1:0] s1_abs;
    logic [4:0]           s1_lz;
    logic [`LEN_WORD-2:0] norm;
    logic                 round_up;
    float_t               res;

    // min int stays 0x80000000 as an unsigned magnitude
    assign abs_val = rs1[`LEN_WORD-1] ? ~rs1 + 1'b1 : rs1;

    // last hit is the highest set bit
    always_comb begin
        lz = '0;
        for (int i = 0; i < `LEN_WORD; i++) begin
            if (abs_val[i])
                lz = 5'(`LEN_WORD - 1 - i);
        end
    end

    // leading one shifted out of bit 30, only the fraction is left
    assign norm     = 31'(s1_abs << s1_lz);
    assign round_up = norm[7] & ((|norm[6:0]) | norm[8]);

    // carry of the rounding ripples into the exponent
    always_comb begin
        res.sign = s1_sign;
        {res.exp, res.frac} = {8'd158 - {3'b0, s1_lz}, norm[30:8]} + 31'(round_up);
        if (s1_zero)
            res = '0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= order;
            done     <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (order) begin
            s1_sign <= rs1[`LEN_WORD-1];
            s1_zero <= (rs1 == '0);
            s1_abs  <= abs_val;
            s1_lz   <= lz;
        end
        if (s1_valid)
            rd <= res;
    end

endmodule

`default_nettype wire

// File: source/ftoi.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_settings.svh"

module ftoi
    import fpu_pkg::*;
(
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  order,
    input  wire [`LEN_WORD-1:0]  rs1,
    output logic                 done,
    output logic [`LEN_WORD-1:0] rd
);

    float_t               op;
    logic                 is_nan;
    logic                 big;
    logic                 s1_valid;
    logic                 s1_sign;
    logic                 s1_sat_pos;
    logic                 s1_sat_neg;
    logic                 s1_small;
    logic [23:0]          s1_sig;
    logic [4:0]           s1_shift;
    logic [`LEN_WORD-1:0] mag;
    logic [`LEN_WORD-1:0] result;

    assign op     = rs1;
    assign is_nan = (&op.exp) && (|op.frac);
    // magnitude at or above 2^31, infinities included
    assign big    = op.exp >= 8'd158;

    // leading one sits at bit 31, shift right by 31 - unbiased exp
    assign mag = {s1_sig, 8'b0} >> s1_shift;

    always_comb begin
        if (s1_sat_pos)
            result = {1'b0, {(`LEN_WORD-1){1'b1}}};
        else if (s1_sat_neg)
            result = {1'b1, {(`LEN_WORD-1){1'b0}}};
        else if (s1_small)
            result = '0;
        else
            result = s1_sign ? ~mag + 1'b1 : mag;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            done     <= 1'b0;
        end else begin
            s1_valid <= order;
            done     <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (order) begin
            s1_sign    <= op.sign;
            s1_sat_pos <= is_nan | (big & ~op.sign);
            s1_sat_neg <= big & op.sign & ~is_nan;
            s1_small   <= op.exp < 8'd127;
            s1_sig     <= {1'b1, op.frac};
            s1_shift   <= 5'(8'd158 - op.exp);
        end
        if (s1_valid)
            rd <= result;
    end

endmodule

`default_nettype wire

// File: source/fpu_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_settings.svh"

module fpu_unit
    import fpu_pkg::*;
(
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 order,
    input  wire fpu_request_t   request,
    output wire                 accepted,
    output wire                 done,
    output wire [`LEN_WORD-1:0] rd
);

    wire                 sgnj_order;
    wire                 comp_order;
    wire                 itof_order;
    wire                 ftoi_order;
    wire                 sgnj_done;
    wire                 comp_done;
    wire                 itof_done;
    wire                 ftoi_done;
    wire [`LEN_WORD-1:0] sgnj_rd;
    wire [`LEN_WORD-1:0] comp_rd;
    wire [`LEN_WORD-1:0] itof_rd;
    wire [`LEN_WORD-1:0] ftoi_rd;

    fpu_dispatch i_dispatch (
        .clk        (clk),
        .arst_n     (arst_n),
        .order      (order),
        .request    (request),
        .accepted   (accepted),
        .done       (done),
        .rd         (rd),
        .sgnj_order (sgnj_order),
        .comp_order (comp_order),
        .itof_order (itof_order),
        .ftoi_order (ftoi_order),
        .sgnj_done  (sgnj_done),
        .comp_done  (comp_done),
        .itof_done  (itof_done),
        .ftoi_done  (ftoi_done),
        .sgnj_rd    (sgnj_rd),
        .comp_rd    (comp_rd),
        .itof_rd    (itof_rd),
        .ftoi_rd    (ftoi_rd)
    );

    // operands go straight from the request
    fsgnj i_fsgnj (
        .clk    (clk),
        .arst_n (arst_n),
        .order  (sgnj_order),
        .func3  (request.func3),
        .rs1    (request.rs1),
        .rs2    (request.rs2),
        .done   (sgnj_done),
        .rd     (sgnj_rd)
    );

    fcomp i_fcomp (
        .clk    (clk),
        .arst_n (arst_n),
        .order  (comp_order),
        .func3  (request.func3),
        .rs1    (request.rs1),
        .rs2    (request.rs2),
        .done   (comp_done),
        .rd     (comp_rd)
    );

    itof i_itof (
        .clk    (clk),
        .arst_n (arst_n),
        .order  (itof_order),
        .rs1    (request.rs1),
        .done   (itof_done),
        .rd     (itof_rd)
    );

    ftoi i_ftoi (
        .clk    (clk),
        .arst_n (arst_n),
        .order  (ftoi_order),
        .rs1    (request.rs1),
        .done   (ftoi_done),
        .rd     (ftoi_rd)
    );

endmodule

`default_nettype wire

// File: bench/fpu_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fpu_settings.svh"

module fpu_unit_tb
    import fpu_pkg::*;
();

    localparam int num_transactions = 2000;
    localparam int accept_limit     = 8;
    localparam int done_limit       = 8;
    localparam int num_specials     = 22;

    // zeros, ones, infinities, NaNs, integer limits, rounding halfway points
    localparam logic [31:0] special_words [0:num_specials-1] = '{
        32'h00000000, 32'h80000000, 32'h3f800000, 32'hbf800000,
        32'h7f800000, 32'hff800000, 32'h7fc00000, 32'h7f800001,
        32'h7fffffff, 32'h80000001, 32'hffffffff, 32'h00000001,
        32'h01000001, 32'h01000003, 32'h4f000000, 32'hcf000000,
        32'h4effffff, 32'hcf000001, 32'h3f000000, 32'hbf7fffff,
        32'h3fc00000, 32'hc0200000
    };

    logic                 clk;
    logic                 arst_n;
    logic                 order;
    fpu_request_t         request;
    logic                 accepted;
    logic                 done;
    logic [`LEN_WORD-1:0] rd;

    logic [31:0] rand_state = 32'hbb0c;
    // last result the DUT should keep showing on rd
    logic [31:0] held_rd = 32'd0;

    fpu_unit i_dut (
        .clk      (clk),
        .arst_n   (arst_n),
        .order    (order),
        .request  (request),
        .accepted (accepted),
        .done     (done),
        .rd       (rd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want)
            fail_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, want));
    endtask

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // upper bits only, the low ones repeat quickly
    function automatic int pick(input int n);
        return int'((next_rand() >> 16) % n);
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic logic [31:0] pick_operand();
        logic [31:0] w;
        int          mode;
        int          k;
        mode = pick(4);
        w    = random_word();
        case (mode)
            0: w = special_words[pick(num_specials)];
            // small signed integers
            2: begin
                k = pick(32);
                w = w[1] ? -(w >> k) : (w >> k);
            end
            // floats from below one up past the integer range
            3: w = {w[31], 8'(pick(56) + 110), w[22:0]};
            default: ;
        endcase
        return w;
    endfunction

    function automatic logic is_known_func7(input logic [6:0] f7);
        case (f7)
            `FUNC7_FSGNJ, `FUNC7_FCOMP, `FUNC7_ITOF,
            `FUNC7_FTOI, `FUNC7_FMVI, `FUNC7_IMVF: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic fpu_request_t random_request();
        fpu_request_t req;
        int           r;
        int           op;
        req.rs1 = pick_operand();
        r = pick(8);
        // equal values and opposite signs show up often
        if (r == 0)
            req.rs2 = req.rs1;
        else if (r == 1)
            req.rs2 = req.rs1 ^ 32'h80000000;
        else
            req.rs2 = pick_operand();
        req.func3 = 3'(pick(3));
        op = pick(16);
        case (op)
            0, 1, 2:  req.func7 = `FUNC7_FSGNJ;
            3, 4, 5:  req.func7 = `FUNC7_FCOMP;
            6, 7, 8:  req.func7 = `FUNC7_ITOF;
            9, 10, 11: req.func7 = `FUNC7_FTOI;
            12: req.func7 = `FUNC7_FMVI;
            13: req.func7 = `FUNC7_IMVF;
            14: begin
                req.func7 = 7'(pick(128));
                if (is_known_func7(req.func7))
                    req.func7 = 7'h7f;
            end
            default: begin
                // known func7 with a func3 outside the defined codes
                req.func7 = (pick(2) == 0) ? `FUNC7_FSGNJ : `FUNC7_FCOMP;
                req.func3 = 3'(pick(5) + 3);
            end
        endcase
        return req;
    endfunction

    function automatic logic is_nan(input logic [31:0] x);
        return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
    endfunction

    function automatic logic [31:0] sgnj_model(input logic [2:0] f3, input logic [31:0] a,
                                               input logic [31:0] b);
        logic s;
        case (f3)
            `FUNC3_SGNJN: s = ~b[31];
            `FUNC3_SGNJX: s = a[31] ^ b[31];
            default:      s = b[31];
        endcase
        return {s, a[30:0]};
    endfunction

    // signed magnitude mapped onto a signed line, both zeros land on 0
    function automatic logic [31:0] comp_model(input logic [2:0] f3, input logic [31:0] a,
                                               input logic [31:0] b);
        logic signed [32:0] ka;
        logic signed [32:0] kb;
        logic               res;
        if (is_nan(a) || is_nan(b))
            return 32'd0;
        ka = a[31] ? -$signed({2'b0, a[30:0]}) : $signed({2'b0, a[30:0]});
        kb = b[31] ? -$signed({2'b0, b[30:0]}) : $signed({2'b0, b[30:0]});
        case (f3)
            `FUNC3_FEQ: res = (ka == kb);
            `FUNC3_FLT: res = (ka < kb);
            default:    res = (ka <= kb);
        endcase
        return {31'd0, res};
    endfunction

    function automatic logic [31:0] itof_model(input logic [31:0] x);
        logic [31:0] mag;
        logic [31:0] kept;
        logic [31:0] rem;
        logic [31:0] half;
        logic [7:0]  e;
        int          msb;
        int          sh;
        if (x == 32'd0)
            return 32'd0;
        mag = x[31] ? -x : x;
        msb = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i])
                msb = i;
        end
        e = 8'(127 + msb);
        if (msb <= 23) begin
            kept = mag << (23 - msb);
        end else begin
            sh   = msb - 23;
            kept = mag >> sh;
            rem  = mag & ((32'd1 << sh) - 32'd1);
            half = 32'd1 << (sh - 1);
            // nearest, ties to even
            if (rem > half || (rem == half && kept[0]))
                kept = kept + 32'd1;
            if (kept[24]) begin
                kept = kept >> 1;
                e    = e + 8'd1;
            end
        end
        return {x[31], e, kept[22:0]};
    endfunction

    function automatic logic [31:0] ftoi_model(input logic [31:0] x);
        logic [7:0]  e;
        logic [31:0] sig;
        logic [31:0] mag;
        e = x[30:23];
        if (is_nan(x))
            return 32'h7fffffff;
        if (e < 8'd127)
            return 32'd0;
        if (e >= 8'd158)
            return x[31] ? 32'h80000000 : 32'h7fffffff;
        sig = {8'd0, 1'b1, x[22:0]};
        if (e >= 8'd150)
            mag = sig << (e - 8'd150);
        else
            mag = sig >> (8'd150 - e);
        return x[31] ? -mag : mag;
    endfunction

    function automatic int latency_of(input fpu_request_t req);
        case (req.func7)
            `FUNC7_FSGNJ: return (req.func3 <= `FUNC3_SGNJX) ? 1 : 0;
            `FUNC7_FCOMP: return (req.func3 <= `FUNC3_FEQ) ? 1 : 0;
            `FUNC7_ITOF, `FUNC7_FTOI: return 2;
            default: return 0;
        endcase
    endfunction

    function automatic logic [31:0] expected_result(input fpu_request_t req);
        case (req.func7)
            `FUNC7_FSGNJ:
                return (req.func3 <= `FUNC3_SGNJX) ?
                    sgnj_model(req.func3, req.rs1, req.rs2) : 32'd0;
            `FUNC7_FCOMP:
                return (req.func3 <= `FUNC3_FEQ) ?
                    comp_model(req.func3, req.rs1, req.rs2) : 32'd0;
            `FUNC7_ITOF: return itof_model(req.rs1);
            `FUNC7_FTOI: return ftoi_model(req.rs1);
            `FUNC7_FMVI, `FUNC7_IMVF: return req.rs1;
            default: return 32'd0;
        endcase
    endfunction

    // follow is the next order, presented early while the DUT is busy when hold is set
    task automatic run_transaction(input fpu_request_t req, input fpu_request_t follow,
                                   input logic hold);
        logic [31:0] want;
        int          want_lat;
        int          waited;
        int          lat;
        want     = expected_result(req);
        want_lat = latency_of(req);
        waited   = 0;
        lat      = 0;
        @(posedge clk);
        #5;
        order   = 1'b1;
        request = req;
        @(negedge clk);
        while (!accepted) begin
            check("done", {31'd0, done}, 32'd0);
            check("rd", rd, held_rd);
            waited++;
            if (waited > accept_limit)
                fail_run("Timeout: accepted did not rise for a pending order");
            @(negedge clk);
        end
        // previous order is finished, so the transfer is immediate
        check("accept wait", 32'(waited), 32'd0);
        while (!done) begin
            check("rd", rd, held_rd);
            lat++;
            if (lat > done_limit)
                fail_run("Timeout: done did not arrive after an accepted order");
            @(posedge clk);
            #5;
            if (hold) begin
                order   = 1'b1;
                request = follow;
            end else begin
                order = 1'b0;
            end
            @(negedge clk);
            // still busy through the done cycle
            check("accepted", {31'd0, accepted}, 32'd0);
        end
        check("done latency", 32'(lat), 32'(want_lat));
        check("rd", rd, want);
        held_rd = want;
    endtask

    initial begin
        fpu_request_t cur;
        fpu_request_t nxt;
        logic         hold;
        order   = 1'b0;
        request = '0;
        arst_n  = 1'b0;
        repeat (2) @(posedge clk);
        #5;
        arst_n = 1'b1;
        @(negedge clk);
        check("accepted", {31'd0, accepted}, 32'd0);
        check("done", {31'd0, done}, 32'd0);
        check("rd", rd, 32'd0);
        nxt = random_request();
        for (int n = 0; n < num_transactions; n++) begin
            cur  = nxt;
            nxt  = random_request();
            hold = (pick(4) == 0);
            run_transaction(cur, nxt, hold);
        end
        @(posedge clk);
        #5;
        order = 1'b0;
        // idle, rd keeps the last result
        repeat (3) begin
            @(negedge clk);
            check("done", {31'd0, done}, 32'd0);
            check("rd", rd, held_rd);
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: fpu_unit.f
+incdir+source
source/fpu_pkg.sv
source/fpu_dispatch.sv
source/fsgnj.sv
source/fcomp.sv
source/itof.sv
source/ftoi.sv
source/fpu_unit.sv
bench/fpu_unit_tb.sv

// File: Makefile
# Verilator build of the FPU single-cycle class and its testbench
TOP = fpu_unit_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): fpu_unit.f source/*.sv source/*.svh bench/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f fpu_unit.f

lint:
	verilator --lint-only -Wall --timing --top-module fpu_unit -f fpu_unit.f

clean:
	rm -rf obj_dir
